// ==== ntm_data_pkg.sv ====
/*
 * NTM write unit data path definitions
 * Signed Q8.8 fixed-point word, full product width and the
 * saturation limits used by the update pipeline
 */

`default_nettype none

package ntm_data_pkg;

  ////////////////////////////////////////
  // Word format
  ////////////////////////////////////////

  localparam int DATA_W    = 16;
  localparam int FRAC_BITS = 8;
  localparam int PROD_W    = 2 * DATA_W;

  // One memory, weight or key element
  typedef logic signed [DATA_W-1:0] ntm_word_t;

  // Full precision product before rounding
  typedef logic signed [PROD_W-1:0] ntm_prod_t;

  // Saturation limits
  localparam ntm_word_t WORD_MAX = 16'sh7FFF;
  localparam ntm_word_t WORD_MIN = -16'sh8000;

  // Half an LSB of the result, added before the shift for round half up
  localparam ntm_prod_t ROUND_HALF = ntm_prod_t'(1) <<< (FRAC_BITS - 1);

endpackage

`default_nettype wire

// ==== ntm_ctrl_pkg.sv ====
/*
 * NTM write unit control definitions
 * Runtime size limits, index and size types and the
 * write sequencer states
 */

`default_nettype none

package ntm_ctrl_pkg;

  ////////////////////////////////////////
  // Size limits
  ////////////////////////////////////////

  localparam int MAX_N = 16;
  localparam int MAX_W = 16;

  // Index covers the larger of the two dimensions
  localparam int INDEX_W = $clog2((MAX_N > MAX_W) ? MAX_N : MAX_W);
  // One extra bit so a size of 16 fits
  localparam int SIZE_W  = INDEX_W + 1;

  typedef logic [SIZE_W-1:0]  ntm_size_t;
  typedef logic [INDEX_W-1:0] ntm_index_t;

  ////////////////////////////////////////
  // Write sequencer states
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    LOAD_A,
    LOAD_W,
    UPDATE,
    DRAIN
  } ntm_write_state_t;

endpackage

`default_nettype wire

// ==== ntm_key_buffer.sv ====
/*
 * Add vector buffer
 * Holds a(k) for the whole operation, one word per write strobe,
 * read back asynchronously by column index
 */

`timescale 1ns/1ps
`default_nettype none

module ntm_key_buffer
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  wire        CLK,
  input  wire        RST,

  // Write side, driven during LOAD_A
  input  wire        write,
  input  ntm_index_t write_index,
  input  ntm_word_t  write_data,

  // Read side, indexed by the current column
  input  ntm_index_t read_index,
  output ntm_word_t  read_data
);

  // Register array, one entry per column
  ntm_word_t key_mem [MAX_W];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < MAX_W; i++) begin
        key_mem[i] <= '0;
      end
    end else if (write) begin
      key_mem[write_index] <= write_data;
    end
  end

  // Combinational read
  // so a(k) meets the old word in the issue cycle
  assign read_data = key_mem[read_index];

endmodule

`default_nettype wire

// ==== ntm_update_pipe.sv ====
/*
 * NTM update pipeline
 * Stage 1 forms w(j)*a(k), rounded half up and saturated to a word
 * Stage 2 adds the old memory word with saturation
 * Row end and operation end markers travel alongside the data
 */

`timescale 1ns/1ps
`default_nettype none

module ntm_update_pipe
  import ntm_data_pkg::*;
(
  input  wire       CLK,
  input  wire       RST,

  // Issue side
  input  wire       issue,
  input  ntm_word_t weight,
  input  ntm_word_t key,
  input  ntm_word_t old_word,
  input  wire       row_last,
  input  wire       op_last,

  // Result side
  output ntm_word_t new_word,
  output logic      new_valid,
  output wire       new_row_last,
  output wire       done
);

  ////////////////////////////////////////
  // Stage 1, product
  ////////////////////////////////////////

  ntm_prod_t prod_full;
  ntm_prod_t prod_round;
  ntm_prod_t prod_shift;
  ntm_word_t prod_sat;

  // Stage 1 registers
  logic      s1_valid;
  logic      s1_row_last;
  logic      s1_op_last;
  ntm_word_t s1_prod;
  ntm_word_t s1_old;

  // Stage 2 marker bits
  logic      s2_row_last;
  logic      s2_op_last;

  // Full 32-bit signed product
  assign prod_full  = weight * key;
  // Round half up, then drop the fraction bits
  assign prod_round = prod_full + ROUND_HALF;
  assign prod_shift = prod_round >>> FRAC_BITS;

  // Clamp the scaled product to the word range
  always_comb begin
    if (prod_shift > ntm_prod_t'(WORD_MAX)) begin
      prod_sat = WORD_MAX;
    end else if (prod_shift < ntm_prod_t'(WORD_MIN)) begin
      prod_sat = WORD_MIN;
    end else begin
      prod_sat = prod_shift[DATA_W-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
    end
  end

  // Payload and markers only move with an issued element
  always_ff @(posedge CLK) begin
    if (issue) begin
      s1_prod     <= prod_sat;
      s1_old      <= old_word;
      s1_row_last <= row_last;
      s1_op_last  <= op_last;
    end
  end

  ////////////////////////////////////////
  // Stage 2, sum
  ////////////////////////////////////////

  logic signed [DATA_W:0] sum_wide;
  ntm_word_t              sum_sat;

  // One guard bit catches the overflow
  assign sum_wide = s1_prod + s1_old;

  always_comb begin
    if (sum_wide[DATA_W] != sum_wide[DATA_W-1]) begin
      sum_sat = sum_wide[DATA_W] ? WORD_MIN : WORD_MAX;
    end else begin
      sum_sat = sum_wide[DATA_W-1:0];
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      new_word    <= '0;
      new_valid   <= 1'b0;
      s2_row_last <= 1'b0;
      s2_op_last  <= 1'b0;
    end else begin
      new_valid <= s1_valid;
      if (s1_valid) begin
        new_word    <= sum_sat;
        s2_row_last <= s1_row_last;
        s2_op_last  <= s1_op_last;
      end
    end
  end

  // Markers only count with a valid word
  assign new_row_last = new_valid & s2_row_last;
  assign done         = new_valid & s2_op_last;

endmodule

`default_nettype wire

// ==== ntm_write_control.sv ====
/*
 * NTM write sequencer
 * Latches the sizes on start, loads a(k), then for each row takes
 * w(j) and turns every accepted old word into one pipeline issue
 * Waits in DRAIN for the last result before going idle
 */

`timescale 1ns/1ps
`default_nettype none

module ntm_write_control
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  wire        CLK,
  input  wire        RST,

  // Host strobes
  input  wire        start,
  input  ntm_size_t  size_n,
  input  ntm_size_t  size_w,
  input  wire        a_in_enable,
  input  wire        w_in_enable,
  input  wire        m_in_enable,
  input  ntm_word_t  w_in,

  // Last result has left the pipeline
  input  wire        pipe_done,

  // Key buffer control
  output wire        buf_write,
  output ntm_index_t buf_write_index,
  output ntm_index_t buf_read_index,

  // Pipeline issue
  output wire        issue,
  output ntm_word_t  issue_weight,
  output wire        issue_row_last,
  output wire        issue_op_last
);

  ////////////////////////////////////////
  // State and counters
  ////////////////////////////////////////

  ntm_write_state_t state;
  ntm_size_t        size_n_q;
  ntm_size_t        size_w_q;
  ntm_index_t       k_count;
  ntm_index_t       j_count;
  ntm_word_t        weight_q;

  logic             w_accept;
  logic             k_last;
  logic             j_last;

  // Last column and last row of the latched sizes
  assign k_last = (ntm_size_t'(k_count) + ntm_size_t'(1)) == size_w_q;
  assign j_last = (ntm_size_t'(j_count) + ntm_size_t'(1)) == size_n_q;

  // Strobes only count in their own phase
  assign buf_write = (state == LOAD_A) && a_in_enable;
  assign w_accept  = (state == LOAD_W) && w_in_enable;
  assign issue     = (state == UPDATE) && m_in_enable;

  assign buf_write_index = k_count;
  assign buf_read_index  = k_count;

  assign issue_weight   = weight_q;
  assign issue_row_last = k_last;
  assign issue_op_last  = k_last && j_last;

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      size_n_q <= '0;
      size_w_q <= '0;
      k_count  <= '0;
      j_count  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            size_n_q <= size_n;
            size_w_q <= size_w;
            k_count  <= '0;
            j_count  <= '0;
            state    <= LOAD_A;
          end
        end
        LOAD_A: begin
          // One a(k) per strobe
          if (buf_write) begin
            if (k_last) begin
              k_count <= '0;
              state   <= LOAD_W;
            end else begin
              k_count <= k_count + 1'b1;
            end
          end
        end
        LOAD_W: begin
          if (w_accept) begin
            state <= UPDATE;
          end
        end
        UPDATE: begin
          if (issue) begin
            if (!k_last) begin
              k_count <= k_count + 1'b1;
            end else if (j_last) begin
              // Last element of the operation issued
              k_count <= '0;
              j_count <= '0;
              state   <= DRAIN;
            end else begin
              k_count <= '0;
              j_count <= j_count + 1'b1;
              state   <= LOAD_W;
            end
          end
        end
        DRAIN: begin
          // start ignored here
          if (pipe_done) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // w(j) held for the whole row
  always_ff @(posedge CLK) begin
    if (w_accept) begin
      weight_q <= w_in;
    end
  end

endmodule

`default_nettype wire

// ==== ntm_write_top.sv ====
/*
 * NTM memory write unit
 * New M(j,k) = M(j,k) + w(j)*a(k), streamed row by row
 * Sequencer, add vector buffer and update pipeline
 */

`timescale 1ns/1ps
`default_nettype none

module ntm_write_top
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  wire       CLK,
  input  wire       RST,

  // Control
  input  wire       start,
  input  ntm_size_t size_n,
  input  ntm_size_t size_w,
  output wire       ready,

  // Input streams
  input  ntm_word_t a_in,
  input  wire       a_in_enable,
  input  ntm_word_t w_in,
  input  wire       w_in_enable,
  input  ntm_word_t m_in,
  input  wire       m_in_enable,

  // Output stream
  output ntm_word_t m_out,
  output wire       m_out_enable,
  output wire       m_out_j_enable
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////

  // Key buffer
  wire        buf_write;
  ntm_index_t buf_write_index;
  ntm_index_t buf_read_index;
  ntm_word_t  key_word;

  // Pipeline issue
  wire        issue;
  ntm_word_t  issue_weight;
  wire        issue_row_last;
  wire        issue_op_last;

  ntm_write_control u_control (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .size_n         (size_n),
    .size_w         (size_w),
    .a_in_enable    (a_in_enable),
    .w_in_enable    (w_in_enable),
    .m_in_enable    (m_in_enable),
    .w_in           (w_in),
    .pipe_done      (ready),
    .buf_write      (buf_write),
    .buf_write_index(buf_write_index),
    .buf_read_index (buf_read_index),
    .issue          (issue),
    .issue_weight   (issue_weight),
    .issue_row_last (issue_row_last),
    .issue_op_last  (issue_op_last)
  );

  // a_in goes straight into the buffer
  ntm_key_buffer u_key_buffer (
    .CLK        (CLK),
    .RST        (RST),
    .write      (buf_write),
    .write_index(buf_write_index),
    .write_data (a_in),
    .read_index (buf_read_index),
    .read_data  (key_word)
  );

  // m_in is the old word, taken in the issue cycle
  ntm_update_pipe u_update_pipe (
    .CLK         (CLK),
    .RST         (RST),
    .issue       (issue),
    .weight      (issue_weight),
    .key         (key_word),
    .old_word    (m_in),
    .row_last    (issue_row_last),
    .op_last     (issue_op_last),
    .new_word    (m_out),
    .new_valid   (m_out_enable),
    .new_row_last(m_out_j_enable),
    .done        (ready)
  );

endmodule

`default_nettype wire

// ==== tb_ntm_checker.sv ====
/*
 * NTM write unit checker
 * Follows the strobe phases on the DUT inputs, models the update rule
 * and compares every output word, marker and its arrival cycle
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ntm_checker
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;
(
  input  wire       CLK,
  input  wire       RST,

  // DUT inputs
  input  wire       start,
  input  ntm_size_t size_n,
  input  ntm_size_t size_w,
  input  ntm_word_t a_in,
  input  wire       a_in_enable,
  input  ntm_word_t w_in,
  input  wire       w_in_enable,
  input  ntm_word_t m_in,
  input  wire       m_in_enable,

  // DUT outputs
  input  ntm_word_t m_out,
  input  wire       m_out_enable,
  input  wire       m_out_j_enable,
  input  wire       ready,

  // Running totals for the testbench top
  output int        errors,
  output int        checked
);

  // Phases as seen from the host side
  localparam int PH_IDLE   = 0;
  localparam int PH_LOAD_A = 1;
  localparam int PH_LOAD_W = 2;
  localparam int PH_UPDATE = 3;
  localparam int PH_DRAIN  = 4;

  int mode;
  int rows;
  int cols;
  int k;
  int j;
  int weight;
  int cycle;
  int key_model [MAX_W];

  // Expected results in issue order
  int exp_word     [$];
  bit exp_row_last [$];
  bit exp_op_last  [$];
  int exp_due      [$];

  ////////////////////////////////////////
  // Update rule model
  ////////////////////////////////////////

  function automatic int clamp_word(input longint v);
    if (v > 32767) begin
      return 32767;
    end
    if (v < -32768) begin
      return -32768;
    end
    return int'(v);
  endfunction

  function automatic int expected_word(input int old_word, input int w, input int a);
    longint p;
    longint q;
    // Q8.8 times Q8.8, plus half an output LSB
    p = longint'(w) * longint'(a) + 128;
    // Floor of p / 256, division alone truncates toward zero
    q = p / 256;
    if ((p < 0) && ((p % 256) != 0)) begin
      q = q - 1;
    end
    return clamp_word(longint'(clamp_word(q)) + longint'(old_word));
  endfunction

  ////////////////////////////////////////
  // Compare, then follow the inputs
  ////////////////////////////////////////

  always @(posedge CLK or posedge RST) begin
    int got_word;
    int want_word;
    bit want_row;
    bit want_op;
    int want_due;
    bit drain_done;
    bit row_end;
    if (RST) begin
      mode    = PH_IDLE;
      k       = 0;
      j       = 0;
      cycle   = 0;
      errors  = 0;
      checked = 0;
      exp_word.delete();
      exp_row_last.delete();
      exp_op_last.delete();
      exp_due.delete();
    end else begin
      cycle      = cycle + 1;
      drain_done = 1'b0;
      // Output values here belong to the cycle that just ended
      if (m_out_enable) begin
        if (exp_word.size() == 0) begin
          $display("ERROR at %0t: output word %0d with nothing in flight", $time, m_out);
          errors++;
        end else begin
          want_word = exp_word.pop_front();
          want_row  = exp_row_last.pop_front();
          want_op   = exp_op_last.pop_front();
          want_due  = exp_due.pop_front();
          got_word  = m_out;
          checked++;
          if (got_word != want_word) begin
            $display("MISMATCH at %0t: m_out expected %0d got %0d", $time, want_word, got_word);
            errors++;
          end
          if (m_out_j_enable != want_row) begin
            $display("MISMATCH at %0t: m_out_j_enable expected %0b got %0b",
                     $time, want_row, m_out_j_enable);
            errors++;
          end
          if (ready != want_op) begin
            $display("MISMATCH at %0t: ready expected %0b got %0b", $time, want_op, ready);
            errors++;
          end
          if (cycle != want_due) begin
            $display("MISMATCH at %0t: word due in cycle %0d arrived in cycle %0d",
                     $time, want_due, cycle);
            errors++;
          end
          drain_done = want_op;
        end
      end else if (m_out_j_enable || ready) begin
        $display("ERROR at %0t: row end or ready marker without an output word", $time);
        errors++;
      end

      // Overdue words were lost
      while ((exp_due.size() > 0) && (exp_due[0] < cycle)) begin
        $display("ERROR at %0t: expected word %0d never came out", $time, exp_word[0]);
        errors++;
        void'(exp_word.pop_front());
        void'(exp_row_last.pop_front());
        void'(exp_op_last.pop_front());
        void'(exp_due.pop_front());
      end

      // Each strobe counts only in its own phase
      case (mode)
        PH_IDLE: begin
          if (start) begin
            rows = int'(size_n);
            cols = int'(size_w);
            k    = 0;
            j    = 0;
            mode = PH_LOAD_A;
          end
        end
        PH_LOAD_A: begin
          if (a_in_enable) begin
            key_model[k] = a_in;
            if (k == cols - 1) begin
              k    = 0;
              mode = PH_LOAD_W;
            end else begin
              k++;
            end
          end
        end
        PH_LOAD_W: begin
          if (w_in_enable) begin
            weight = w_in;
            mode   = PH_UPDATE;
          end
        end
        PH_UPDATE: begin
          if (m_in_enable) begin
            row_end = (k == cols - 1);
            exp_word.push_back(expected_word(m_in, weight, key_model[k]));
            exp_row_last.push_back(row_end);
            exp_op_last.push_back(row_end && (j == rows - 1));
            // Two cycles after the strobe, seen here two edges on
            exp_due.push_back(cycle + 2);
            if (!row_end) begin
              k++;
            end else if (j == rows - 1) begin
              k    = 0;
              j    = 0;
              mode = PH_DRAIN;
            end else begin
              k    = 0;
              j++;
              mode = PH_LOAD_W;
            end
          end
        end
        default: begin
          // Start ignored until the last word is out
          if (drain_done) begin
            mode = PH_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tb_ntm_write.sv ====
/*
 * NTM write unit testbench
 * Seeded random operations with stray strobes, extreme values
 * and back-to-back elements; results compared by the checker
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ntm_write
  import ntm_data_pkg::*;
  import ntm_ctrl_pkg::*;
();

  localparam int NUM_TESTS = 10;
  localparam int STRAY_M   = 0;
  localparam int STRAY_W   = 1;

  logic      CLK;
  logic      RST;
  logic      start;
  ntm_size_t size_n;
  ntm_size_t size_w;
  ntm_word_t a_in;
  ntm_word_t w_in;
  ntm_word_t m_in;
  logic      a_in_enable;
  logic      w_in_enable;
  logic      m_in_enable;
  ntm_word_t m_out;
  wire       m_out_enable;
  wire       m_out_j_enable;
  wire       ready;

  int        chk_errors;
  int        chk_checked;
  int        cycle_count;
  int        cycle_limit;

  // Test table, drawn before the run
  int        t_rows [NUM_TESTS];
  int        t_cols [NUM_TESTS];
  int        t_gap  [NUM_TESTS];
  int        t_vals [NUM_TESTS];

  ntm_write_top DUT (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .size_n        (size_n),
    .size_w        (size_w),
    .ready         (ready),
    .a_in          (a_in),
    .a_in_enable   (a_in_enable),
    .w_in          (w_in),
    .w_in_enable   (w_in_enable),
    .m_in          (m_in),
    .m_in_enable   (m_in_enable),
    .m_out         (m_out),
    .m_out_enable  (m_out_enable),
    .m_out_j_enable(m_out_j_enable)
  );

  tb_ntm_checker u_checker (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .size_n        (size_n),
    .size_w        (size_w),
    .a_in          (a_in),
    .a_in_enable   (a_in_enable),
    .w_in          (w_in),
    .w_in_enable   (w_in_enable),
    .m_in          (m_in),
    .m_in_enable   (m_in_enable),
    .m_out         (m_out),
    .m_out_enable  (m_out_enable),
    .m_out_j_enable(m_out_j_enable),
    .ready         (ready),
    .errors        (chk_errors),
    .checked       (chk_checked)
  );

  ////////////////////////////////////////
  // Clock and run limit
  ////////////////////////////////////////

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count++;
    if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic clear_strobes();
    start       = 1'b0;
    a_in_enable = 1'b0;
    w_in_enable = 1'b0;
    m_in_enable = 1'b0;
  endtask

  // Random word, or one from a set that hits saturation and exact halves
  function automatic ntm_word_t pick_word(input int vals);
    if ((vals == 0) || ((vals == 2) && ($urandom % 2 == 0))) begin
      return ntm_word_t'($urandom);
    end
    case ($urandom % 8)
      0:       return 16'sh7FFF;
      1:       return 16'sh8000;
      2:       return 16'sh0080;  // 0.5
      3:       return 16'sh0001;
      4:       return 16'shFFFF;
      5:       return 16'shFF80;  // -0.5
      6:       return 16'sh0100;  // 1.0
      default: return 16'sh7F80;
    endcase
  endfunction

  // 0 to max_gap idle cycles, some with a strobe the DUT must ignore
  task automatic idle_gap(input int max_gap, input int stray);
    int n;
    n = int'($urandom % (max_gap + 1));
    repeat (n) begin
      @(negedge CLK);
      clear_strobes();
      if ($urandom % 2 == 1) begin
        if (stray == STRAY_M) begin
          m_in_enable = 1'b1;
          m_in        = ntm_word_t'($urandom);
        end else begin
          w_in_enable = 1'b1;
          w_in        = ntm_word_t'($urandom);
        end
      end
    end
  endtask

  // One whole operation, entered and left at a falling edge
  task automatic run_op(input int rows, input int cols, input int max_gap, input int vals);
    clear_strobes();
    start  = 1'b1;
    size_n = ntm_size_t'(rows);
    size_w = ntm_size_t'(cols);
    @(negedge CLK);
    clear_strobes();
    // Add vector, stray old words during LOAD_A
    for (int k = 0; k < cols; k++) begin
      idle_gap(max_gap, STRAY_M);
      @(negedge CLK);
      clear_strobes();
      a_in        = pick_word(vals);
      a_in_enable = 1'b1;
    end
    for (int j = 0; j < rows; j++) begin
      // Stray old words during LOAD_W
      idle_gap(max_gap, STRAY_M);
      @(negedge CLK);
      clear_strobes();
      w_in        = pick_word(vals);
      w_in_enable = 1'b1;
      for (int k = 0; k < cols; k++) begin
        // Stray weights during UPDATE
        idle_gap(max_gap, STRAY_W);
        @(negedge CLK);
        clear_strobes();
        m_in        = pick_word(vals);
        m_in_enable = 1'b1;
      end
    end
    // Start in DRAIN, must be ignored
    @(negedge CLK);
    clear_strobes();
    start  = 1'b1;
    size_n = ntm_size_t'(1 + $urandom % 16);
    size_w = ntm_size_t'(1 + $urandom % 16);
    @(negedge CLK);
    clear_strobes();
    while (!ready) begin
      @(negedge CLK);
    end
    @(negedge CLK);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int seed_dummy;
    int limit;
    int prev_errors;
    int prev_checked;
    int failed_tests;
    int count_errors;
    seed_dummy   = int'($urandom(25008));
    cycle_count  = 0;
    cycle_limit  = 0;
    failed_tests = 0;
    count_errors = 0;
    RST          = 1'b1;
    size_n       = '0;
    size_w       = '0;
    a_in         = '0;
    w_in         = '0;
    m_in         = '0;
    clear_strobes();

    // Corner sizes first, back-to-back extremes, then random mixes
    t_rows = '{1, 16, 16, 1, 4, 0, 0, 0, 0, 0};
    t_cols = '{1, 16, 16, 1, 4, 0, 0, 0, 0, 0};
    t_gap  = '{3, 3, 0, 0, 2, 3, 3, 3, 0, 3};
    t_vals = '{0, 0, 1, 1, 1, 0, 1, 2, 2, 2};
    for (int t = 5; t < NUM_TESTS; t++) begin
      t_rows[t] = 1 + int'($urandom % 16);
      t_cols[t] = 1 + int'($urandom % 16);
    end

    // Four cycles per strobe at the largest gap
    limit = 16 + 10;
    for (int t = 0; t < NUM_TESTS; t++) begin
      limit += (t_cols[t] + t_rows[t] * (t_cols[t] + 1)) * 4 + 50;
    end
    cycle_limit = limit;

    repeat (16) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    for (int t = 0; t < NUM_TESTS; t++) begin
      prev_errors  = chk_errors;
      prev_checked = chk_checked;
      run_op(t_rows[t], t_cols[t], t_gap[t], t_vals[t]);
      $display("test %0d: %0d x %0d, max gap %0d, %0d words, %0d errors", t, t_rows[t],
               t_cols[t], t_gap[t], chk_checked - prev_checked, chk_errors - prev_errors);
      if (chk_checked - prev_checked != t_rows[t] * t_cols[t]) begin
        $display("test %0d: wrong number of output words, wanted %0d", t,
                 t_rows[t] * t_cols[t]);
        count_errors++;
      end
      if ((chk_errors != prev_errors) ||
          (chk_checked - prev_checked != t_rows[t] * t_cols[t])) begin
        failed_tests++;
      end
    end

    $display("Summary: %0d tests, %0d failed, %0d words checked, %0d errors",
             NUM_TESTS, failed_tests, chk_checked, chk_errors + count_errors);
    if ((chk_errors == 0) && (count_errors == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
ntm_data_pkg.sv
ntm_ctrl_pkg.sv
ntm_key_buffer.sv
ntm_update_pipe.sv
ntm_write_control.sv
ntm_write_top.sv
tb_ntm_checker.sv
tb_ntm_write.sv

// ==== Makefile ====
# Verilator simulation of the NTM write unit

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_ntm_write \
		-f vlog.f --Mdir obj_dir -o sim_ntm_write
	./obj_dir/sim_ntm_write | tee $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
